/* flist.f */
src/datapathPkg.sv
src/registerFile.sv
src/busMux.sv
src/specialRegisters.sv
src/alu.sv
src/dataPath.sv
testbench/dataPathTb.sv

/* run.sh */
#!/bin/sh
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f flist.f --top-module dataPathTb -o simDataPath

./obj_dir/simDataPath 2>&1 | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

/* testbench/dataPathTb.sv */
// datapath testbench with clock, reset, bus tasks, ALU reference model, result checker and watchdog
module dataPathTb;
    timeunit 1ns;
    timeprecision 1ps;
    import datapathPkg::*;

    localparam int NumRegs = 16;
    localparam int NumTests = 6;
    localparam int MaxWait = 40;                        // cycles allowed until finished
    localparam int WatchdogNs = NumTests * 200 * 100;
    // bus source and destination codes
    localparam int selRf = 0, selPc = 1, selIr = 2, selY = 3, selZLo = 4;
    localparam int selZHi = 5, selMar = 6, selHi = 7, selLo = 8, selMdr = 9;

    logic Clock, rst, start, memRead, mdrIn, incPc, finished;
    logic rfOut, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, rHiOut, rLoOut, mdrOut;
    logic rfIn, pcIn, irIn, ryIn, rzIn, marIn, rHiIn, rLoIn;
    regSel_t rfSelect;
    aluOp_t  opSelect;
    word_t   memDataIn, busData, address;

    integer  seed;
    int      errorCount, checkCount, failedTests, testErrors;
    word_t   rfExpect [NumRegs];    // what each general register should hold
    word_t   valA, valB;
    regSel_t sel;
    aluOp_t  checkOp;               // operation and operands of the result under check
    word_t   checkA, checkB;
    dword_t  seenZ;
    event    aluResultReady;
    aluOp_t  singleOps [13] = '{aluAdd, aluSub, aluAnd, aluOr, aluNeg, aluNot, aluShr,
                                aluShra, aluShl, aluRor, aluRol, 5'b00000, 5'b11111};

    dataPath #(.NumRegs(NumRegs)) u_dataPath (.*);

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;     // 100 ns period
    end

    task automatic nextCycle();
        @(posedge Clock);
        #5;
    endtask

    task automatic clearStrobes();
        {rfOut, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, rHiOut, rLoOut, mdrOut} = '0;
        {rfIn, pcIn, irIn, ryIn, rzIn, marIn, rHiIn, rLoIn} = '0;
        {incPc, start, memRead, mdrIn} = '0;
    endtask

    task automatic finishCycle();
        nextCycle();
        clearStrobes();
    endtask

    task automatic setOut(int src, logic level);
        case (src)
            selRf:   rfOut = level;
            selPc:   pcOut = level;
            selIr:   irOut = level;
            selY:    ryOut = level;
            selZLo:  rzLoOut = level;
            selZHi:  rzHiOut = level;
            selMar:  marOut = level;
            selHi:   rHiOut = level;
            selLo:   rLoOut = level;
            default: mdrOut = level;
        endcase
    endtask

    task automatic setIn(int dst, logic level);
        case (dst)
            selRf:          rfIn = level;
            selPc:          pcIn = level;
            selIr:          irIn = level;
            selY:           ryIn = level;
            selZLo, selZHi: rzIn = level;
            selMar:         marIn = level;
            selHi:          rHiIn = level;
            selLo:          rLoIn = level;
            default:        mdrIn = level;  // bus into MDR while memRead is low
        endcase
    endtask

    task automatic compareValue(string name, dword_t expected, dword_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] time %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // memory word into MDR, then over the bus into the destination
    task automatic loadReg(int dst, regSel_t rs, word_t value);
        memDataIn = value;
        memRead = 1'b1;
        mdrIn = 1'b1;
        finishCycle();
        if (dst != selMdr) begin
            rfSelect = rs;
            mdrOut = 1'b1;
            setIn(dst, 1'b1);
            finishCycle();
        end
    endtask

    task automatic moveReg(int src, regSel_t srcSel, int dst, regSel_t dstSel);
        rfSelect = (src == selRf) ? srcSel : dstSel;   // one selector for both rf ports
        setOut(src, 1'b1);
        setIn(dst, 1'b1);
        finishCycle();
    endtask

    task automatic readBus(int src, regSel_t rs, output word_t value);
        rfSelect = rs;
        setOut(src, 1'b1);
        @(negedge Clock);
        value = busData;
    endtask

    task automatic readReg(int src, regSel_t rs, word_t expected, string name);
        word_t value;
        readBus(src, rs, value);
        compareValue(name, {32'd0, expected}, {32'd0, value});
        finishCycle();
    endtask

    // two sources at once, the bus must show the higher priority one
    task automatic checkPriority(int winner, int loser, regSel_t rs, word_t expected);
        setOut(loser, 1'b1);
        readReg(winner, rs, expected, "busData priority");
    endtask

    task automatic runAlu(aluOp_t op, int bSrc, regSel_t bSel, word_t aVal, word_t bVal);
        int    cycles;
        word_t zLo;
        word_t zHi;
        opSelect = op;
        start = 1'b1;
        rzIn = 1'b1;                    // held until Z has captured
        rfSelect = bSel;
        setOut(bSrc, 1'b1);
        nextCycle();
        start = 1'b0;
        setOut(bSrc, 1'b0);
        cycles = 0;
        do begin
            @(negedge Clock);
            cycles++;
        end while (finished !== 1'b1 && cycles < MaxWait);
        if (finished !== 1'b1) begin
            errorCount++;
            $display("ALU operation %b never raised finished within %0d cycles", op, MaxWait);
        end
        compareValue("finished latency", 64'((op == aluMul || op == aluDiv) ? 33 : 1),
                     64'(cycles));
        finishCycle();                  // Z loads on this edge
        @(negedge Clock);
        compareValue("finished", 64'd0, 64'(finished));
        nextCycle();
        readBus(selZLo, 4'd0, zLo);
        finishCycle();
        readBus(selZHi, 4'd0, zHi);
        checkOp = op;
        checkA = aVal;
        checkB = bVal;
        seenZ = {zHi, zLo};
        -> aluResultReady;
        finishCycle();
    endtask

    task automatic aluCase(aluOp_t op, word_t a, word_t b);
        loadReg(selY, 4'd0, a);
        loadReg(selMdr, 4'd0, b);
        runAlu(op, selMdr, 4'd0, a, b);
    endtask

    // expected 64-bit Z for operand A from Y and operand B from the bus
    function automatic dword_t aluModel(aluOp_t op, word_t a, word_t b);
        logic [4:0] amount;
        logic [5:0] rest;
        word_t      low;
        longint     sa;
        longint     sb;
        longint     q;
        longint     r;
        amount = b[4:0];
        rest = 6'd32 - {1'b0, amount};  // bits that wrap around on a rotate
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            aluAdd:  low = a + b;
            aluSub:  low = a - b;
            aluAnd:  low = a & b;
            aluOr:   low = a | b;
            aluNeg:  low = 32'd0 - b;
            aluNot:  low = ~b;
            aluShr:  low = a >> amount;
            aluShra: low = (a >> amount) | (a[31] ? ~(32'hFFFF_FFFF >> amount) : 32'd0);
            aluShl:  low = a << amount;
            aluRor:  low = (a >> amount) | (a << rest);
            aluRol:  low = (a << amount) | (a >> rest);
            aluMul:  return sa * sb;
            aluDiv: begin
                if (b == 32'd0) return {a, 32'hFFFF_FFFF};
                q = sa / sb;            // truncates toward zero
                r = sa % sb;            // sign of the dividend
                return {r[31:0], q[31:0]};
            end
            default: low = '0;
        endcase
        return {32'd0, low};
    endfunction

    task automatic finishTest(int num, string name);
        if (errorCount == testErrors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", num, name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // compares each ALU result with the model once both Z halves are in
    initial begin
        forever begin
            @(aluResultReady);
            compareValue("Z", aluModel(checkOp, checkA, checkB), seenZ);
        end
    end

    initial begin
        #(WatchdogNs);
        $display("watchdog expired after %0d ns, the tests did not complete", WatchdogNs);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed = 32'h375a;
        errorCount = 0;
        checkCount = 0;
        failedTests = 0;
        testErrors = 0;
        rst = 1'b1;
        clearStrobes();
        rfSelect = '0;
        opSelect = '0;
        memDataIn = '0;
        repeat (8) @(posedge Clock);
        #5;
        rst = 1'b0;

        @(negedge Clock);
        compareValue("finished", 64'd0, 64'(finished));
        compareValue("address", 64'd0, {32'd0, address});
        nextCycle();
        readReg(selPc, 4'd0, '0, "PC");
        readReg(selIr, 4'd0, '0, "IR");
        readReg(selZLo, 4'd0, '0, "Z low");
        readReg(selZHi, 4'd0, '0, "Z high");
        readReg(selHi, 4'd0, '0, "HI");
        readReg(selLo, 4'd0, '0, "LO");
        finishTest(1, "after reset");

        for (int r = 0; r < NumRegs; r++) begin
            rfExpect[r] = $random(seed);
            loadReg(selRf, regSel_t'(r), rfExpect[r]);
        end
        for (int i = 0; i < 4; i++) begin  // overwrite a few random entries
            sel = regSel_t'($random(seed));
            rfExpect[sel] = $random(seed);
            loadReg(selRf, sel, rfExpect[sel]);
        end
        for (int r = 0; r < NumRegs; r++) begin
            readReg(selRf, regSel_t'(r), rfExpect[r], "rfData");
        end
        valA = $random(seed);
        valB = $random(seed);
        loadReg(selHi, 4'd0, valA);
        loadReg(selLo, 4'd0, valB);
        loadReg(selPc, 4'd0, valA ^ valB);
        checkPriority(selRf, selPc, 4'd5, rfExpect[5]);
        checkPriority(selPc, selHi, 4'd0, valA ^ valB);
        checkPriority(selHi, selLo, 4'd0, valA);
        checkPriority(selLo, selMdr, 4'd0, valB);
        finishTest(2, "register file and bus priority");

        valA = $random(seed);
        valB = $random(seed);
        loadReg(selPc, 4'd0, valA);
        moveReg(selPc, 4'd0, selIr, 4'd0);
        moveReg(selIr, 4'd0, selY, 4'd0);
        readReg(selY, 4'd0, valA, "Y");
        loadReg(selMar, 4'd0, valB);
        compareValue("address", {32'd0, valB}, {32'd0, address});
        moveReg(selY, 4'd0, selHi, 4'd0);
        moveReg(selMar, 4'd0, selLo, 4'd0);
        readReg(selIr, 4'd0, valA, "IR");
        readReg(selHi, 4'd0, valA, "HI");
        readReg(selLo, 4'd0, valB, "LO");
        moveReg(selHi, 4'd0, selMdr, 4'd0);     // memRead low, MDR takes the bus
        readReg(selMdr, 4'd0, valA, "MDR from bus");
        incPc = 1'b1;
        finishCycle();
        readReg(selPc, 4'd0, valA + 32'd1, "PC after incPc");
        rLoOut = 1'b1;                  // bus load beats the increment
        pcIn = 1'b1;
        incPc = 1'b1;
        finishCycle();
        readReg(selPc, 4'd0, valB, "PC after pcIn");
        finishTest(3, "special registers");

        foreach (singleOps[k]) begin
            for (int i = 0; i < 2; i++) begin
                valA = $random(seed);
                valB = $random(seed);
                aluCase(singleOps[k], valA, valB);
            end
            if (singleOps[k] >= aluShr && singleOps[k] <= aluRol) begin
                valA = $random(seed);
                valB = $random(seed);   // upper bits of B must not matter
                aluCase(singleOps[k], valA, {valB[31:5], 5'd0});
                aluCase(singleOps[k], valA, {valB[31:5], 5'd31});
            end
        end
        finishTest(4, "single-cycle ALU operations");

        valA = $random(seed);
        valB = $random(seed);
        aluCase(aluMul, valA, valB);
        aluCase(aluMul, 32'hFFFF_FFF9, valB);
        aluCase(aluMul, valA | 32'h8000_0000, valB | 32'h8000_0000);
        aluCase(aluMul, 32'h8000_0000, 32'h8000_0000);
        aluCase(aluDiv, valA, valB >> 12);
        aluCase(aluDiv, valA | 32'h8000_0000, 32'd7);
        aluCase(aluDiv, 32'd1000, 32'hFFFF_FFF3);
        aluCase(aluDiv, valA, 32'd0);
        aluCase(aluDiv, 32'h8000_0000, 32'hFFFF_FFFF);
        finishTest(5, "multiply and divide");

        loadReg(selRf, 4'd2, 32'd8);
        loadReg(selRf, 4'd3, 32'd2);
        loadReg(selIr, 4'd0, 32'hC891_8000);
        moveReg(selRf, 4'd2, selY, 4'd0);
        runAlu(aluShr, selRf, 4'd3, 32'd8, 32'd2);
        moveReg(selZLo, 4'd0, selRf, 4'd1);
        readReg(selRf, 4'd1, 32'd2, "R1");
        readReg(selIr, 4'd0, 32'hC891_8000, "IR");
        finishTest(6, "shift right sequence");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 NumTests, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* src/dataPath.sv */
// single-bus datapath top level joining register file, special registers, ALU and bus mux
module dataPath #(
    parameter int NumRegs = 16
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 rfOut,
    input  logic                 pcOut,
    input  logic                 irOut,
    input  logic                 ryOut,
    input  logic                 rzLoOut,
    input  logic                 rzHiOut,
    input  logic                 marOut,
    input  logic                 rHiOut,
    input  logic                 rLoOut,
    input  logic                 mdrOut,
    input  logic                 rfIn,
    input  logic                 pcIn,
    input  logic                 irIn,
    input  logic                 ryIn,
    input  logic                 rzIn,
    input  logic                 marIn,
    input  logic                 rHiIn,
    input  logic                 rLoIn,
    input  logic                 incPc,
    input  datapathPkg::regSel_t rfSelect,
    input  datapathPkg::aluOp_t  opSelect,
    input  logic                 start,
    input  logic                 memRead,
    input  logic                 mdrIn,
    input  datapathPkg::word_t   memDataIn,
    output logic                 finished,
    output datapathPkg::word_t   busData,
    output datapathPkg::word_t   address
);
    import datapathPkg::*;

    word_t  rfData;
    word_t  pcData;
    word_t  irData;
    word_t  yData;
    dword_t zData;
    word_t  marData;
    word_t  hiData;
    word_t  loData;
    word_t  mdrData;
    dword_t aluResult;

    assign address = marData;   // memory address comes straight from MAR

    registerFile #(.NumRegs(NumRegs)) u_registerFile (
        .Clock(Clock), .rst(rst), .rfIn(rfIn), .rfSelect(rfSelect),
        .busData(busData), .rfData(rfData)
    );

    specialRegisters u_specialRegisters (
        .Clock(Clock), .rst(rst), .busData(busData), .memDataIn(memDataIn),
        .aluResult(aluResult), .finished(finished),
        .pcIn(pcIn), .incPc(incPc), .irIn(irIn), .ryIn(ryIn), .rzIn(rzIn),
        .marIn(marIn), .rHiIn(rHiIn), .rLoIn(rLoIn), .mdrIn(mdrIn), .memRead(memRead),
        .pcData(pcData), .irData(irData), .yData(yData), .zData(zData),
        .marData(marData), .hiData(hiData), .loData(loData), .mdrData(mdrData)
    );

    // operand A from Y, operand B straight off the bus
    alu u_alu (
        .Clock(Clock), .rst(rst), .start(start), .opSelect(opSelect),
        .operandA(yData), .operandB(busData),
        .finished(finished), .result(aluResult)
    );

    busMux u_busMux (
        .rfOut(rfOut), .pcOut(pcOut), .irOut(irOut), .ryOut(ryOut),
        .rzLoOut(rzLoOut), .rzHiOut(rzHiOut), .marOut(marOut),
        .rHiOut(rHiOut), .rLoOut(rLoOut), .mdrOut(mdrOut),
        .rfData(rfData), .pcData(pcData), .irData(irData), .yData(yData),
        .zData(zData), .marData(marData), .hiData(hiData), .loData(loData),
        .mdrData(mdrData), .busData(busData)
    );

endmodule

/* src/alu.sv */
// ALU with start/finished sequencing, iterative signed multiply and restoring divide
module alu (
    input  logic                Clock,
    input  logic                rst,
    input  logic                start,
    input  datapathPkg::aluOp_t opSelect,
    input  datapathPkg::word_t  operandA,
    input  datapathPkg::word_t  operandB,
    output logic                finished,
    output datapathPkg::dword_t result
);
    import datapathPkg::*;

    aluState_t  state;
    aluOp_t     opReg;
    word_t      aReg;
    word_t      bReg;
    dword_t     work;       // mul: {acc, multiplier}, div: {remainder, quotient}
    logic [4:0] iterCount;
    word_t      bMag;
    logic [32:0] mulSum;
    logic [32:0] divShift;
    logic [32:0] divDiff;
    dword_t     divNext;
    dword_t     rotRight;
    dword_t     rotLeft;
    logic [4:0] shiftAmt;
    word_t      shortResult;
    dword_t     product;
    word_t      quotient;
    word_t      remainder;
    dword_t     divResult;

    function automatic word_t magnitude(input word_t value);
        return value[31] ? -value : value;  // 0x80000000 stays as 2^31
    endfunction

    assign finished = (state == done);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state     <= idle;
            opReg     <= '0;
            iterCount <= '0;
        end else begin
            case (state)
                idle: if (start) begin
                    opReg     <= opSelect;
                    iterCount <= '0;
                    state     <= (opSelect == aluMul || opSelect == aluDiv) ? busy : done;
                end
                busy: begin
                    iterCount <= iterCount + 5'd1;
                    if (iterCount == 5'd31) state <= done; // 32nd step
                end
                default: state <= idle; // done lasts one cycle
            endcase
        end
    end

    // operand and work registers
    always_ff @(posedge Clock) begin
        if (state == idle && start) begin
            aReg <= operandA;
            bReg <= operandB;
            work <= {32'd0, magnitude(operandA)};
        end else if (state == busy) begin
            work <= (opReg == aluMul) ? {mulSum, work[31:1]} : divNext;
        end
    end

    assign bMag = magnitude(bReg);

    // one shift-and-add step on magnitudes
    assign mulSum = {1'b0, work[63:32]} + (work[0] ? {1'b0, bMag} : 33'd0);

    // one restoring division step
    assign divShift = {work[63:32], work[31]};
    assign divDiff  = divShift - {1'b0, bMag};
    assign divNext  = (divShift >= {1'b0, bMag}) ? {divDiff[31:0], work[30:0], 1'b1}
                                                  : {divShift[31:0], work[30:0], 1'b0};

    // sign fixes
    assign product   = (aReg[31] ^ bReg[31]) ? -work : work;
    assign quotient  = (aReg[31] ^ bReg[31]) ? -work[31:0] : work[31:0];
    assign remainder = aReg[31] ? -work[63:32] : work[63:32];   // follows dividend sign
    assign divResult = (bReg == '0) ? {aReg, 32'hFFFF_FFFF} : {remainder, quotient};

    assign shiftAmt = bReg[4:0];
    assign rotRight = {aReg, aReg} >> shiftAmt;
    assign rotLeft  = {aReg, aReg} << shiftAmt;

    always_comb begin
        case (opReg)
            aluAdd:  shortResult = aReg + bReg;
            aluSub:  shortResult = aReg - bReg;
            aluAnd:  shortResult = aReg & bReg;
            aluOr:   shortResult = aReg | bReg;
            aluNeg:  shortResult = -bReg;   // unary ops work on the bus operand
            aluNot:  shortResult = ~bReg;
            aluShr:  shortResult = aReg >> shiftAmt;
            aluShra: shortResult = word_t'($signed(aReg) >>> shiftAmt);
            aluShl:  shortResult = aReg << shiftAmt;
            aluRor:  shortResult = rotRight[31:0];
            aluRol:  shortResult = rotLeft[63:32];
            default: shortResult = '0;
        endcase
    end

    always_comb begin
        if (opReg == aluMul) begin
            result = product;
        end else if (opReg == aluDiv) begin
            result = divResult;
        end else begin
            result = {32'd0, shortResult};
        end
    end

endmodule

/* src/specialRegisters.sv */
// PC, IR, Y, Z, MAR, MDR, HI and LO registers with their load rules
module specialRegisters (
    input  logic                Clock,
    input  logic                rst,
    input  datapathPkg::word_t  busData,
    input  datapathPkg::word_t  memDataIn,
    input  datapathPkg::dword_t aluResult,
    input  logic                finished,
    input  logic                pcIn,
    input  logic                incPc,
    input  logic                irIn,
    input  logic                ryIn,
    input  logic                rzIn,
    input  logic                marIn,
    input  logic                rHiIn,
    input  logic                rLoIn,
    input  logic                mdrIn,
    input  logic                memRead,
    output datapathPkg::word_t  pcData,
    output datapathPkg::word_t  irData,
    output datapathPkg::word_t  yData,
    output datapathPkg::dword_t zData,
    output datapathPkg::word_t  marData,
    output datapathPkg::word_t  hiData,
    output datapathPkg::word_t  loData,
    output datapathPkg::word_t  mdrData
);

    // program counter, a bus load overrides the increment
    always_ff @(posedge Clock) begin
        if (rst) begin
            pcData <= '0;
        end else if (pcIn) begin
            pcData <= busData;
        end else if (incPc) begin
            pcData <= pcData + 32'd1;
        end
    end

    // plain bus-loaded registers
    always_ff @(posedge Clock) begin
        if (rst) begin
            irData  <= '0;
            yData   <= '0;
            marData <= '0;
            hiData  <= '0;
            loData  <= '0;
        end else begin
            if (irIn)  irData  <= busData;
            if (ryIn)  yData   <= busData;  // ALU operand A
            if (marIn) marData <= busData;
            if (rHiIn) hiData  <= busData;
            if (rLoIn) loData  <= busData;
        end
    end

    // Z only captures on the cycle the ALU reports its result
    always_ff @(posedge Clock) begin
        if (rst) begin
            zData <= '0;
        end else if (finished && rzIn) begin
            zData <= aluResult;
        end
    end

    // MDR takes memory data during a read, the bus otherwise
    always_ff @(posedge Clock) begin
        if (rst) begin
            mdrData <= '0;
        end else if (mdrIn) begin
            mdrData <= memRead ? memDataIn : busData;
        end
    end

endmodule

/* src/busMux.sv */
// shared bus source selection by fixed strobe priority
module busMux (
    input  logic                rfOut,
    input  logic                pcOut,
    input  logic                irOut,
    input  logic                ryOut,
    input  logic                rzLoOut,
    input  logic                rzHiOut,
    input  logic                marOut,
    input  logic                rHiOut,
    input  logic                rLoOut,
    input  logic                mdrOut,
    input  datapathPkg::word_t  rfData,
    input  datapathPkg::word_t  pcData,
    input  datapathPkg::word_t  irData,
    input  datapathPkg::word_t  yData,
    input  datapathPkg::dword_t zData,
    input  datapathPkg::word_t  marData,
    input  datapathPkg::word_t  hiData,
    input  datapathPkg::word_t  loData,
    input  datapathPkg::word_t  mdrData,
    output datapathPkg::word_t  busData
);

    // first strobe in the chain wins, an idle bus reads zero
    always_comb begin
        if (rfOut) begin
            busData = rfData;
        end else if (pcOut) begin
            busData = pcData;
        end else if (irOut) begin
            busData = irData;
        end else if (ryOut) begin
            busData = yData;
        end else if (rzLoOut) begin
            busData = zData[31:0];  // low half of Z
        end else if (rzHiOut) begin
            busData = zData[63:32]; // high half of Z
        end else if (marOut) begin
            busData = marData;
        end else if (rHiOut) begin
            busData = hiData;
        end else if (rLoOut) begin
            busData = loData;
        end else if (mdrOut) begin
            busData = mdrData;
        end else begin
            busData = '0;
        end
    end

endmodule

/* src/registerFile.sv */
// general purpose register file with one write port and one read port
module registerFile #(
    parameter int NumRegs = 16
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 rfIn,
    input  datapathPkg::regSel_t rfSelect,
    input  datapathPkg::word_t   busData,
    output datapathPkg::word_t   rfData
);
    import datapathPkg::*;

    word_t regs [NumRegs];
    logic  selValid;

    assign selValid = (int'(rfSelect) < NumRegs); // selectors past the last entry do nothing

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (rfIn && selValid) begin
            regs[rfSelect] <= busData;
        end
    end

    // read side follows the selector in the same cycle
    always_comb begin
        if (selValid) begin
            rfData = regs[rfSelect];
        end else begin
            rfData = '0;
        end
    end

endmodule

/* src/datapathPkg.sv */
// datapath word types, register selector type, ALU operation codes and ALU state type
package datapathPkg;

    typedef logic [31:0] word_t;    // bus and register word
    typedef logic [63:0] dword_t;   // full ALU result held in Z
    typedef logic [3:0]  regSel_t;  // general register selector
    typedef logic [4:0]  aluOp_t;   // ALU operation code

    // arithmetic and logic
    localparam aluOp_t aluAdd  = 5'b00011;
    localparam aluOp_t aluSub  = 5'b00100;
    localparam aluOp_t aluAnd  = 5'b00101;
    localparam aluOp_t aluOr   = 5'b00110;
    localparam aluOp_t aluMul  = 5'b01111;  // multi-cycle
    localparam aluOp_t aluDiv  = 5'b10000;  // multi-cycle
    localparam aluOp_t aluNeg  = 5'b10001;
    localparam aluOp_t aluNot  = 5'b10010;

    // shifts and rotates, amount taken from B[4:0]
    localparam aluOp_t aluShr  = 5'b11001;
    localparam aluOp_t aluShra = 5'b11010;
    localparam aluOp_t aluShl  = 5'b11011;
    localparam aluOp_t aluRor  = 5'b11100;
    localparam aluOp_t aluRol  = 5'b11101;

    // ALU sequencing
    typedef enum logic [1:0] {
        idle,   // waiting for start
        busy,   // multiply or divide iterating
        done    // result valid, finished high
    } aluState_t;

endpackage
